// File: Makefile
# Verilator flow for the demod monitoring core

VERILATOR  ?= verilator
FILELIST   ?= compile.f
TB_TOP     ?= demodTb
RTL_TOP    ?= demodTop
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
PASS_TEXT  ?= Simulation PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TB_TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TB_TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
sim: $(BUILD_DIR)/V$(TB_TOP)
	@out="$$(./$(BUILD_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: compile.f
verilog/demodPkg.sv
verilog/demodRegs.sv
verilog/fmDiscriminator.sv
verilog/falseLockDetector.sv
verilog/dacOutputMux.sv
verilog/demodTop.sv
dv/demodTb.sv

// File: dv/demodTb.sv
`timescale 1ns/1ps
`default_nettype none

module demodTb;
    import demodPkg::*;

    localparam int numDacs = 3;

    logic     clk;
    logic     rstN;
    regAddr_t addr;
    regData_t din;
    byteWr_t  wr;
    logic     sampleEn;
    sample_t  iRx;
    sample_t  qRx;
    logic     carrierLock;
    regData_t dout;
    logic     highFreqOffset;
    logic     dacSync [numDacs];
    sample_t  dacData [numDacs];
    dacSel_t  dacSelect [numDacs];

    // model stage 1 lines up with fmEn and stage 2 with the DAC outputs
    logic        s1Valid;
    logic        s2Valid;
    sample_t     s1I;
    sample_t     s1Q;
    sample_t     s1Fm;
    sample_t     s2I;
    sample_t     s2Q;
    sample_t     s2Fm;
    sample_t     prevI;
    sample_t     prevQ;
    sample_t     avgModel;
    logic [17:0] absModel;
    logic        flagModel;
    sample_t     expDac [numDacs];

    // software view of the control registers
    logic        swapModel;
    dacSel_t     selModel [numDacs];
    alpha_t      alphaModel;
    threshold_t  thresholdModel;

    logic        readCheck;
    regData_t    expRead;
    logic [31:0] lfsrState;
    int          errorCount;
    int          testCount;
    bit          timedOut;

    demodTop #(
        .numDacs(numDacs)
    ) DUT (
        .clk            (clk),
        .rstN           (rstN),
        .addr           (addr),
        .din            (din),
        .wr             (wr),
        .sampleEn       (sampleEn),
        .iRx            (iRx),
        .qRx            (qRx),
        .carrierLock    (carrierLock),
        .dout           (dout),
        .highFreqOffset (highFreqOffset),
        .dacSync        (dacSync),
        .dacData        (dacData),
        .dacSelect      (dacSelect)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic regAddr_t demodAddr(input logic [3:0] offset);
        return {demodBase, offset};
    endfunction

    // previous I times current Q minus previous Q times current I
    function automatic sample_t crossProduct(input sample_t iOld, qOld, iNew, qNew);
        longint diff;
        diff = longint'(iOld) * longint'(qNew) - longint'(qOld) * longint'(iNew);
        return diff[34:17];
    endfunction

    function automatic logic [17:0] magnitude(input sample_t value);
        return value[17] ? -value : value;
    endfunction

    // alpha * new + (1 - alpha) * old with alpha scaled by 4
    function automatic logic [17:0] blend(input longint newValue, oldValue, input alpha_t alpha);
        longint weight;
        longint total;
        weight = longint'(alpha) * 4;
        total  = newValue * weight + oldValue * (longint'(unityFraction) - weight);
        return total[34:17];
    endfunction

    always @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            s1Valid   <= 1'b0;
            s2Valid   <= 1'b0;
            {s1I, s1Q, s1Fm, s2I, s2Q, s2Fm} <= '0;
            {prevI, prevQ, avgModel, absModel} <= '0;
            flagModel <= 1'b0;
        end else begin
            s1Valid <= sampleEn;
            s2Valid <= s1Valid;
            s2I     <= s1I;
            s2Q     <= s1Q;
            s2Fm    <= s1Fm;
            if (sampleEn) begin
                s1I   <= swapModel ? qRx : iRx;
                s1Q   <= swapModel ? iRx : qRx;
                s1Fm  <= crossProduct(prevI, prevQ, iRx, qRx);
                prevI <= iRx;
                prevQ <= qRx;
            end
            if (s1Valid) begin
                avgModel <= blend(longint'(s1Fm), longint'(avgModel), alphaModel);
                absModel <= blend(longint'(magnitude(s1Fm)), longint'(absModel), alphaModel);
                // flag uses the averages from before this update
                if (absModel > hardOffsetLimit) begin
                    flagModel <= 1'b1;
                end else if (magnitude(avgModel) > {2'b00, thresholdModel}) begin
                    flagModel <= !carrierLock;
                end else begin
                    flagModel <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        for (int k = 0; k < numDacs; k++) begin
            case (selModel[k])
                dacQ:    expDac[k] = s2Q;
                dacFm:   expDac[k] = s2Fm;
                default: expDac[k] = s2I;
            endcase
        end
    end

    for (genvar k = 0; k < numDacs; k++) begin : gDacCheck
        dacSyncCheck: assert property (@(posedge clk) disable iff (!rstN)
            dacSync[k] == s2Valid)
            else begin
                $display("CHECK FAILED at %0t: dacSync[%0d] expected %0b actual %0b",
                         $time, k, s2Valid, dacSync[k]);
                errorCount++;
            end
        dacDataCheck: assert property (@(posedge clk) disable iff (!rstN)
            s2Valid |-> dacData[k] == expDac[k])
            else begin
                $display("CHECK FAILED at %0t: dacData[%0d] expected %h actual %h",
                         $time, k, expDac[k], dacData[k]);
                errorCount++;
            end
        dacSelectCheck: assert property (@(posedge clk) disable iff (!rstN)
            dacSelect[k] == selModel[k])
            else begin
                $display("CHECK FAILED at %0t: dacSelect[%0d] expected %h actual %h",
                         $time, k, selModel[k], dacSelect[k]);
                errorCount++;
            end
    end

    flagCheck: assert property (@(posedge clk) disable iff (!rstN)
        highFreqOffset == flagModel)
        else begin
            $display("CHECK FAILED at %0t: highFreqOffset expected %0b actual %0b",
                     $time, flagModel, highFreqOffset);
            errorCount++;
        end

    readBackCheck: assert property (@(posedge clk) disable iff (!rstN)
        readCheck |-> dout == expRead)
        else begin
            $display("CHECK FAILED at %0t: dout expected %h actual %h", $time, expRead, dout);
            errorCount++;
        end

    task automatic regWrite(input regAddr_t a, input regData_t data, input byteWr_t strobes);
        @(posedge clk);
        addr <= a;
        din  <= data;
        wr   <= strobes;
        @(posedge clk);
        wr   <= '0;
    endtask

    task automatic regRead(input regAddr_t a, input regData_t expected);
        @(posedge clk);
        addr      <= a;
        expRead   <= expected;
        readCheck <= 1'b1;
        @(posedge clk);
        readCheck <= 1'b0;
    endtask

    task automatic sendSample(input sample_t i, input sample_t q);
        @(posedge clk);
        sampleEn <= 1'b1;
        iRx      <= i;
        qRx      <= q;
        @(posedge clk);
        sampleEn <= 1'b0;
    endtask

    task automatic randomSample(output sample_t value);
        for (int b = 0; b < $bits(sample_t); b++) begin
            lfsrState = lfsrNext(lfsrState);
            value[b]  = lfsrState[0];
        end
    endtask

    task automatic sendRandom(input int count);
        sample_t i;
        sample_t q;
        repeat (count) begin
            randomSample(i);
            randomSample(q);
            sendSample(i, q);
        end
        repeat (4) @(posedge clk);
    endtask

    // four points a quarter turn apart give a constant positive fm
    task automatic waitFlag(input logic level, input sample_t amp);
        int turns;
        turns = 0;
        while (highFreqOffset !== level && turns < 100) begin
            sendSample(amp, '0);
            sendSample('0, amp);
            sendSample(-amp, '0);
            sendSample('0, -amp);
            turns++;
        end
        if (highFreqOffset !== level) begin
            $display("TIMEOUT highFreqOffset did not reach %0b after %0d turns", level, turns);
            timedOut = 1'b1;
        end
    endtask

    task automatic reportTest(input string name);
        testCount++;
        $display("test %0d %s finished, %0d errors so far", testCount, name, errorCount);
    endtask

    task automatic endRun();
        $display("tests %0d errors %0d timeouts %0d", testCount, errorCount, timedOut);
        if (errorCount == 0 && !timedOut) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    endtask

    initial begin
        {errorCount, testCount, timedOut} = '0;
        lfsrState   = 32'h4e40;
        rstN        = 1'b0;
        {addr, din, wr, iRx, qRx} = '0;
        sampleEn    = 1'b0;
        carrierLock = 1'b0;
        readCheck   = 1'b0;
        expRead     = '0;
        swapModel   = 1'b0;
        selModel    = '{default: dacI};
        alphaModel  = '0;
        thresholdModel = '0;
        repeat (3) @(posedge clk);
        rstN <= 1'b1;

        for (int r = 0; r <= 4; r++) begin
            regRead(demodAddr(4'(r)), '0);
        end
        regWrite(demodAddr(regFalseLockThreshold), 32'hDEAD_BE34, 4'b0001);
        regRead(demodAddr(regFalseLockThreshold), 32'h0000_0034);
        regWrite(demodAddr(regFalseLockThreshold), 32'h1234_5678, 4'b0010);
        regRead(demodAddr(regFalseLockThreshold), 32'h0000_5634);
        thresholdModel <= 16'h5634;
        // byte 1 of the select word only has bits 11:8
        regWrite(demodAddr(regDacSelect), 32'hFFFF_FAFF, 4'b0010);
        selModel[2] <= 4'hA;
        regRead(demodAddr(regDacSelect), 32'h0000_0A00);
        regWrite(demodAddr(regFalseLockAlpha), 32'hABCD_1000, 4'b1111);
        alphaModel <= 16'h1000;
        regWrite(12'h501, 32'hFFFF_FFFF, 4'b1111);
        regRead(demodAddr(regFalseLockAlpha), 32'h0000_1000);
        regRead(12'h3F1, '0);
        regRead(demodAddr(4'd7), '0);
        reportTest("register access");

        // ch0 I, ch1 Q, ch2 I
        regWrite(demodAddr(regDacSelect), 32'h0000_0010, 4'b0011);
        selModel <= '{dacI, dacQ, dacI};
        sendRandom(16);
        regWrite(demodAddr(regControl), 32'h1, 4'b0001);
        swapModel <= 1'b1;
        sendRandom(16);
        regWrite(demodAddr(regControl), 32'h0, 4'b0001);
        swapModel <= 1'b0;
        reportTest("sample path and swap");

        regWrite(demodAddr(regDacSelect), 32'h0000_0210, 4'b0011);
        selModel[2] <= dacFm;
        sendRandom(24);
        reportTest("fm discriminator");

        regWrite(demodAddr(regFalseLockThreshold), 32'd8000, 4'b0011);
        thresholdModel <= 16'd8000;
        waitFlag(1'b1, 18'sd40000);
        if (!timedOut) begin
            @(posedge clk);
            carrierLock <= 1'b1;
            waitFlag(1'b0, 18'sd40000);
        end
        reportTest("false lock with threshold");

        if (!timedOut) begin
            waitFlag(1'b1, 18'sd120000);
            regRead(demodAddr(regStatus), 32'h0000_0003);
        end
        reportTest("hard offset limit");
        endRun();
    end

endmodule

`default_nettype wire

// File: verilog/dacOutputMux.sv
`timescale 1ns/1ps
`default_nettype none

module dacOutputMux #(
    parameter int numDacs = 3
) (
    input  logic              clk,
    input  logic              rstN,
    input  logic              sampleEn,
    input  logic              fmEn,
    input  logic              iqSwap,
    input  demodPkg::sample_t iIn,
    input  demodPkg::sample_t qIn,
    input  demodPkg::sample_t fmVideo,
    input  demodPkg::sample_t averageFreq,
    input  demodPkg::sample_t averageAbsFreq,
    input  demodPkg::dacSel_t dacSelect [numDacs],
    output demodPkg::sample_t dacData [numDacs],
    output logic              dacSync [numDacs]
);
    import demodPkg::*;

    sample_t iSwap;
    sample_t qSwap;
    // high the cycle the swapped pair is new
    logic    swapValid;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            iSwap     <= '0;
            qSwap     <= '0;
            swapValid <= 1'b0;
        end else begin
            swapValid <= sampleEn;
            if (sampleEn) begin
                if (iqSwap) begin
                    iSwap <= qIn;
                    qSwap <= iIn;
                end else begin
                    iSwap <= iIn;
                    qSwap <= qIn;
                end
            end
        end
    end

    for (genvar k = 0; k < numDacs; k++) begin : gDac
        always_ff @(posedge clk or negedge rstN) begin
            if (!rstN) begin
                dacData[k] <= '0;
                dacSync[k] <= 1'b0;
            end else begin
                case (dacSource_t'(dacSelect[k]))
                    dacQ: begin
                        dacData[k] <= qSwap;
                        dacSync[k] <= swapValid;
                    end
                    dacFm: begin
                        dacData[k] <= fmVideo;
                        dacSync[k] <= fmEn;
                    end
                    dacAvgFreq: begin
                        dacData[k] <= averageFreq;
                        dacSync[k] <= fmEn;
                    end
                    dacAvgAbsFreq: begin
                        dacData[k] <= averageAbsFreq;
                        dacSync[k] <= fmEn;
                    end
                    default: begin
                        dacData[k] <= iSwap;
                        dacSync[k] <= swapValid;
                    end
                endcase
            end
        end

        // every sync pulse comes from a source strobe
        syncHasStrobe: assert property (@(posedge clk) disable iff (!rstN)
            $rose(dacSync[k]) |-> $past(swapValid || fmEn));
    end

endmodule

`default_nettype wire

// File: verilog/demodPkg.sv
`default_nettype none

package demodPkg;

    // baseband sample, also the DAC data word
    typedef logic signed [17:0] sample_t;

    // full 18x18 product
    typedef logic signed [35:0] product_t;

    // processor bus
    typedef logic [11:0] regAddr_t;
    typedef logic [31:0] regData_t;
    typedef logic [3:0]  byteWr_t;

    // false-lock controls as written by software
    typedef logic [15:0] alpha_t;
    typedef logic [15:0] threshold_t;

    // DAC channel source code
    typedef logic [3:0] dacSel_t;

    // unlisted codes fall back to the I sample
    typedef enum dacSel_t {
        dacI          = 4'd0,
        dacQ          = 4'd1,
        dacFm         = 4'd2,
        dacAvgFreq    = 4'd3,
        dacAvgAbsFreq = 4'd4
    } dacSource_t;

    // addr[11:4] selects the demod space
    localparam logic [7:0] demodBase = 8'h40;

    // word offsets, addr[3:0]
    localparam logic [3:0] regDacSelect          = 4'd0;
    localparam logic [3:0] regFalseLockAlpha     = 4'd1;
    localparam logic [3:0] regFalseLockThreshold = 4'd2;
    localparam logic [3:0] regControl            = 4'd3;
    localparam logic [3:0] regStatus             = 4'd4;

    // absolute average above this forces the offset flag
    localparam logic [17:0] hardOffsetLimit = 18'h10000;

    // 1.0 in the averaging arithmetic
    localparam logic [17:0] unityFraction = 18'h20000;

endpackage

`default_nettype wire

// File: verilog/demodRegs.sv
`timescale 1ns/1ps
`default_nettype none

module demodRegs #(
    parameter int numDacs = 3
) (
    input  logic                   clk,
    input  logic                   rstN,
    input  demodPkg::regAddr_t     addr,
    input  demodPkg::regData_t     din,
    input  demodPkg::byteWr_t      wr,
    input  logic                   highFreqOffset,
    input  logic                   carrierLock,
    output demodPkg::regData_t     dout,
    output demodPkg::dacSel_t      dacSelect [numDacs],
    output demodPkg::alpha_t       falseLockAlpha,
    output demodPkg::threshold_t   falseLockThreshold,
    output logic                   iqSwap
);
    import demodPkg::*;

    localparam int dacSelBits = $bits(dacSel_t) * numDacs;

    logic                  inSpace;
    logic [3:0]            offset;
    logic                  writeEn;
    logic [dacSelBits-1:0] dacSelectWord;
    regData_t              writeData;

    // replace only the strobed bytes of a word
    function automatic regData_t mergeBytes(regData_t oldWord, regData_t newWord,
                                            byteWr_t strobes);
        regData_t result;
        result = oldWord;
        for (int b = 0; b < $bits(byteWr_t); b++) begin
            if (strobes[b]) begin
                result[8*b +: 8] = newWord[8*b +: 8];
            end
        end
        return result;
    endfunction

    assign inSpace = (addr[11:4] == demodBase);
    assign offset  = addr[3:0];
    assign writeEn = inSpace && (wr != '0);

    // readback, zero outside the space
    always_comb begin
        dout = '0;
        if (inSpace) begin
            case (offset)
                regDacSelect:          dout = regData_t'(dacSelectWord);
                regFalseLockAlpha:     dout = regData_t'(falseLockAlpha);
                regFalseLockThreshold: dout = regData_t'(falseLockThreshold);
                regControl:            dout = regData_t'(iqSwap);
                regStatus:             dout = {30'b0, carrierLock, highFreqOffset};
                default:               dout = '0;
            endcase
        end
    end

    // addressed word with the new bytes merged in
    assign writeData = mergeBytes(dout, din, wr);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            dacSelectWord      <= '0;
            falseLockAlpha     <= '0;
            falseLockThreshold <= '0;
            iqSwap             <= 1'b0;
        end else if (writeEn) begin
            case (offset)
                regDacSelect:          dacSelectWord      <= writeData[dacSelBits-1:0];
                regFalseLockAlpha:     falseLockAlpha     <= writeData[15:0];
                regFalseLockThreshold: falseLockThreshold <= writeData[15:0];
                regControl:            iqSwap             <= writeData[0];
                default: begin
                end
            endcase
        end
    end

    // 4 bits per channel, channel 0 in the low nibble
    for (genvar k = 0; k < numDacs; k++) begin : gDacSel
        assign dacSelect[k] = dacSelectWord[4*k +: 4];
    end

    // status is read only, a write there must not touch any control register
    statusNotWritten: assert property (@(posedge clk) disable iff (!rstN)
        (writeEn && offset == regStatus) |=>
            ($stable(dacSelectWord) && $stable(falseLockAlpha)
             && $stable(falseLockThreshold) && $stable(iqSwap)));

endmodule

`default_nettype wire

// File: verilog/demodTop.sv
`timescale 1ns/1ps
`default_nettype none

module demodTop #(
    parameter int numDacs = 3
) (
    input  logic               clk,
    input  logic               rstN,
    input  demodPkg::regAddr_t addr,
    input  demodPkg::regData_t din,
    input  demodPkg::byteWr_t  wr,
    input  logic               sampleEn,
    input  demodPkg::sample_t  iRx,
    input  demodPkg::sample_t  qRx,
    input  logic               carrierLock,
    output demodPkg::regData_t dout,
    output logic               highFreqOffset,
    output logic               dacSync [numDacs],
    output demodPkg::sample_t  dacData [numDacs],
    output demodPkg::dacSel_t  dacSelect [numDacs]
);
    import demodPkg::*;

    alpha_t     falseLockAlpha;
    threshold_t falseLockThreshold;
    logic       iqSwap;
    sample_t    fmVideo;
    logic       fmEn;
    sample_t    averageFreq;
    sample_t    averageAbsFreq;

    demodRegs #(
        .numDacs(numDacs)
    ) regs (
        .clk                (clk),
        .rstN               (rstN),
        .addr               (addr),
        .din                (din),
        .wr                 (wr),
        .highFreqOffset     (highFreqOffset),
        .carrierLock        (carrierLock),
        .dout               (dout),
        .dacSelect          (dacSelect),
        .falseLockAlpha     (falseLockAlpha),
        .falseLockThreshold (falseLockThreshold),
        .iqSwap             (iqSwap)
    );

    fmDiscriminator discriminator (
        .clk      (clk),
        .rstN     (rstN),
        .sampleEn (sampleEn),
        .iIn      (iRx),
        .qIn      (qRx),
        .fmVideo  (fmVideo),
        .fmEn     (fmEn)
    );

    falseLockDetector lockDetector (
        .clk                (clk),
        .rstN               (rstN),
        .fmEn               (fmEn),
        .carrierLock        (carrierLock),
        .fmVideo            (fmVideo),
        .falseLockAlpha     (falseLockAlpha),
        .falseLockThreshold (falseLockThreshold),
        .averageFreq        (averageFreq),
        .averageAbsFreq     (averageAbsFreq),
        .highFreqOffset     (highFreqOffset)
    );

    dacOutputMux #(
        .numDacs(numDacs)
    ) dacMux (
        .clk            (clk),
        .rstN           (rstN),
        .sampleEn       (sampleEn),
        .fmEn           (fmEn),
        .iqSwap         (iqSwap),
        .iIn            (iRx),
        .qIn            (qRx),
        .fmVideo        (fmVideo),
        .averageFreq    (averageFreq),
        .averageAbsFreq (averageAbsFreq),
        .dacSelect      (dacSelect),
        .dacData        (dacData),
        .dacSync        (dacSync)
    );

endmodule

`default_nettype wire

// File: verilog/falseLockDetector.sv
`timescale 1ns/1ps
`default_nettype none

module falseLockDetector (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 fmEn,
    input  logic                 carrierLock,
    input  demodPkg::sample_t    fmVideo,
    input  demodPkg::alpha_t     falseLockAlpha,
    input  demodPkg::threshold_t falseLockThreshold,
    output demodPkg::sample_t    averageFreq,
    output demodPkg::sample_t    averageAbsFreq,
    output logic                 highFreqOffset
);
    import demodPkg::*;

    // coefficients carry one extra bit so that 1.0 stays positive
    logic signed [18:0] alphaFrac;
    logic signed [18:0] oneMinusAlpha;
    logic signed [18:0] absFreqIn;
    logic signed [18:0] absAvgIn;
    product_t           freqNew;
    product_t           freqOld;
    product_t           freqSum;
    product_t           absNew;
    product_t           absOld;
    product_t           absSum;
    logic [17:0]        avgFreqMagnitude;

    assign alphaFrac     = $signed({1'b0, falseLockAlpha, 2'b00});
    assign oneMinusAlpha = $signed({1'b0, unityFraction}) - alphaFrac;

    // magnitudes are unsigned so -1.0 maps to +1.0
    assign absFreqIn = $signed({1'b0, fmVideo[17] ? -fmVideo : fmVideo});
    assign absAvgIn  = $signed({1'b0, averageAbsFreq});

    // signed frequency average
    assign freqNew = fmVideo * alphaFrac;
    assign freqOld = averageFreq * oneMinusAlpha;
    assign freqSum = freqNew + freqOld;

    // absolute frequency average
    assign absNew = absFreqIn * alphaFrac;
    assign absOld = absAvgIn * oneMinusAlpha;
    assign absSum = absNew + absOld;

    assign avgFreqMagnitude = averageFreq[17] ? -averageFreq : averageFreq;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            averageFreq    <= '0;
            averageAbsFreq <= '0;
            highFreqOffset <= 1'b0;
        end else if (fmEn) begin
            averageFreq    <= freqSum[34:17];
            averageAbsFreq <= absSum[34:17];
            // decided from the averages before this update
            if ($unsigned(averageAbsFreq) > hardOffsetLimit) begin
                highFreqOffset <= 1'b1;
            end else if (avgFreqMagnitude > {2'b00, falseLockThreshold}) begin
                // a large mean offset only matters while the loop is out of lock
                highFreqOffset <= !carrierLock;
            end else begin
                highFreqOffset <= 1'b0;
            end
        end
    end

    // flag moves only on a frequency update
    flagOnlyAfterFmEn: assert property (@(posedge clk) disable iff (!rstN)
        !$stable(highFreqOffset) |-> $past(fmEn));

endmodule

`default_nettype wire

// File: verilog/fmDiscriminator.sv
`timescale 1ns/1ps
`default_nettype none

module fmDiscriminator (
    input  logic              clk,
    input  logic              rstN,
    input  logic              sampleEn,
    input  demodPkg::sample_t iIn,
    input  demodPkg::sample_t qIn,
    output demodPkg::sample_t fmVideo,
    output logic              fmEn
);
    import demodPkg::*;

    sample_t  iPrev;
    sample_t  qPrev;
    product_t crossIq;
    product_t crossQi;
    product_t crossDiff;

    // cross product of previous and current sample
    assign crossIq   = iPrev * qIn;
    assign crossQi   = qPrev * iIn;
    assign crossDiff = crossIq - crossQi;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            iPrev   <= '0;
            qPrev   <= '0;
            fmVideo <= '0;
            fmEn    <= 1'b0;
        end else begin
            fmEn <= sampleEn;
            if (sampleEn) begin
                iPrev   <= iIn;
                qPrev   <= qIn;
                // drop the redundant sign bit, keep 18 bits of fraction
                fmVideo <= crossDiff[34:17];
            end
        end
    end

    // one fmEn per sample strobe, and strobes never back to back
    fmEnFollowsSample: assert property (@(posedge clk) disable iff (!rstN)
        sampleEn |=> (fmEn && !sampleEn));

endmodule

`default_nettype wire
